// File: rtl/alu_pkg.sv
package alu_pkg;

	// ============================================================
	// Sizes and widths
	// ============================================================
	localparam int VSIZE     = 4;
	localparam int DATA_BW   = 8;
	localparam int TMP_BW    = 16;
	localparam int REG_NWORD = 16;
	localparam int REG_ABW   = $clog2(REG_NWORD);
	localparam int TBUF_SIZE = 2;

	// One lane of SRAM or DRAM data
	typedef logic [DATA_BW-1:0] data_t;
	// One lane of an internal result
	typedef logic signed [TMP_BW-1:0] tdata_t;
	typedef logic [REG_ABW-1:0] reg_addr_t;
	typedef logic [4:0] shamt_t;

	// ============================================================
	// Opcodes, 5 to 7 are reserved
	// ============================================================
	typedef logic [2:0] opcode_t;
	localparam opcode_t OP_ADD     = 3'd0;
	localparam opcode_t OP_SUB     = 3'd1;
	localparam opcode_t OP_SQDIST  = 3'd2;
	localparam opcode_t OP_ABSDIST = 3'd3;
	localparam opcode_t OP_MAC     = 3'd4;

	// Operand sources
	typedef logic [2:0] src_t;
	localparam src_t SRC_CONST = 3'd0;
	localparam src_t SRC_REG   = 3'd1;
	localparam src_t SRC_SRAM0 = 3'd2;
	localparam src_t SRC_SRAM1 = 3'd3;
	localparam src_t SRC_TBUF0 = 3'd4;
	localparam src_t SRC_TBUF1 = 3'd5;

	// DRAM write mode, 0 to 2 select an extra shift of twice the value
	typedef logic [1:0] dram_mode_t;
	localparam dram_mode_t DRAM_NONE = 2'd3;

	// Lane vectors
	typedef data_t dvec_t [VSIZE];
	typedef tdata_t tvec_t [VSIZE];

endpackage

// File: rtl/alu_wb_if.sv
`timescale 1ns/1ns

interface alu_wb_if;

	// Register file write
	logic              reg_we;
	alu_pkg::reg_addr_t reg_waddr;
	// Temporary buffer push
	logic              tbuf_we;
	// Result vector shared by both sinks
	alu_pkg::tvec_t    wdata;

	modport src (
		output reg_we,
		output reg_waddr,
		output tbuf_we,
		output wdata
	);

	modport reg_sink (
		input reg_we,
		input reg_waddr,
		input wdata
	);

	modport tbuf_sink (
		input tbuf_we,
		input wdata
	);

endinterface

// File: rtl/vec_alu.sv
`timescale 1ns/1ns

module vec_alu (
	// Instruction
	input  logic                 i_op_rdy,
	output logic                 o_op_ack,
	input  alu_pkg::opcode_t     i_opcode,
	input  alu_pkg::shamt_t      i_shamt,
	input  alu_pkg::src_t        i_a,
	input  alu_pkg::src_t        i_b,
	input  alu_pkg::src_t        i_c,
	input  alu_pkg::tdata_t      i_const_a,
	input  alu_pkg::tdata_t      i_const_b,
	input  alu_pkg::tdata_t      i_const_c,
	input  alu_pkg::reg_addr_t   i_reg_raddr,
	input  logic                 i_to_reg,
	input  alu_pkg::reg_addr_t   i_reg_waddr,
	input  logic                 i_to_temp,
	input  alu_pkg::dram_mode_t  i_to_dram,
	// Register file read port
	output alu_pkg::reg_addr_t   o_rf_raddr,
	input  alu_pkg::tvec_t       i_rf_rdata,
	// Temporary buffer entries
	input  alu_pkg::tvec_t       i_tbuf0,
	input  alu_pkg::tvec_t       i_tbuf1,
	// SRAM read streams
	input  logic                 i_sramrd0_rdy,
	output logic                 o_sramrd0_ack,
	input  alu_pkg::dvec_t       i_sramrd0,
	input  logic                 i_sramrd1_rdy,
	output logic                 o_sramrd1_ack,
	input  alu_pkg::dvec_t       i_sramrd1,
	// DRAM write stream
	output logic                 o_dramwd_rdy,
	input  logic                 i_dramwd_ack,
	output alu_pkg::dvec_t       o_dramwd,
	output logic                 o_inst_commit,
	alu_wb_if.src                wb
);

	// ============================================================
	// Operand selection
	// ============================================================
	function automatic alu_pkg::tvec_t sel_operand(
		input alu_pkg::src_t   src,
		input alu_pkg::tdata_t cval
	);
		alu_pkg::tvec_t v;
		for (int i = 0; i < alu_pkg::VSIZE; i++) begin
			case (src)
				alu_pkg::SRC_CONST: v[i] = cval;
				alu_pkg::SRC_REG:   v[i] = i_rf_rdata[i];
				// SRAM bytes are sign-extended
				alu_pkg::SRC_SRAM0: v[i] = alu_pkg::tdata_t'($signed(i_sramrd0[i]));
				alu_pkg::SRC_SRAM1: v[i] = alu_pkg::tdata_t'($signed(i_sramrd1[i]));
				alu_pkg::SRC_TBUF0: v[i] = i_tbuf0[i];
				alu_pkg::SRC_TBUF1: v[i] = i_tbuf1[i];
				default:            v[i] = '0;
			endcase
		end
		return v;
	endfunction

	// ============================================================
	// Lane arithmetic
	// ============================================================
	function automatic alu_pkg::tdata_t lane_calc(
		input alu_pkg::opcode_t op,
		input alu_pkg::shamt_t  sh,
		input alu_pkg::tdata_t  a,
		input alu_pkg::tdata_t  b,
		input alu_pkg::tdata_t  c
	);
		logic signed [8:0]  d8;
		logic signed [17:0] sq;
		logic signed [17:0] sq_sh;
		alu_pkg::tdata_t    sum;
		alu_pkg::tdata_t    dbc;
		alu_pkg::tdata_t    absd;
		alu_pkg::tdata_t    prod;
		alu_pkg::tdata_t    r;
		// Low bytes of b and c are treated as signed for SQDIST and MAC
		d8 = $signed(b[7:0]) - $signed(c[7:0]);
		sq = d8 * d8;
		sq_sh = sq >>> sh;
		dbc = b - c;
		absd = (dbc < 0) ? -dbc : dbc;
		prod = $signed(b[7:0]) * $signed(c[7:0]);
		case (op)
			alu_pkg::OP_ADD: begin
				sum = a + b + c;
				r = sum >>> sh;
			end
			alu_pkg::OP_SUB: begin
				sum = a + b - c;
				r = sum >>> sh;
			end
			alu_pkg::OP_SQDIST:  r = a + alu_pkg::tdata_t'(sq_sh[15:0]);
			alu_pkg::OP_ABSDIST: r = a + (absd >>> sh);
			alu_pkg::OP_MAC:     r = a + (prod >>> sh);
			default:             r = '0;
		endcase
		return r;
	endfunction

	alu_pkg::tvec_t sel_a;
	alu_pkg::tvec_t sel_b;
	alu_pkg::tvec_t sel_c;
	alu_pkg::tvec_t result;
	logic           need_rd0;
	logic           need_rd1;
	logic           data_ready;
	logic           to_dram;
	logic           op_ack;
	logic [2:0]     dram_shift;

	assign o_rf_raddr = i_reg_raddr;

	always_comb begin
		sel_a = sel_operand(i_a, i_const_a);
		sel_b = sel_operand(i_b, i_const_b);
		sel_c = sel_operand(i_c, i_const_c);
	end

	always_comb begin
		for (int i = 0; i < alu_pkg::VSIZE; i++) begin
			result[i] = lane_calc(i_opcode, i_shamt, sel_a[i], sel_b[i], sel_c[i]);
		end
	end

	// DRAM lanes are narrowed after an extra shift of 0, 2 or 4
	assign dram_shift = {i_to_dram, 1'b0};

	always_comb begin
		alu_pkg::tdata_t narrow;
		for (int i = 0; i < alu_pkg::VSIZE; i++) begin
			narrow = result[i] >>> dram_shift;
			o_dramwd[i] = narrow[alu_pkg::DATA_BW-1:0];
		end
	end

	// ============================================================
	// Handshake control
	// ============================================================
	always_comb begin
		need_rd0 = (i_a == alu_pkg::SRC_SRAM0) || (i_b == alu_pkg::SRC_SRAM0)
			|| (i_c == alu_pkg::SRC_SRAM0);
		need_rd1 = (i_a == alu_pkg::SRC_SRAM1) || (i_b == alu_pkg::SRC_SRAM1)
			|| (i_c == alu_pkg::SRC_SRAM1);
		// All operands present for the pending instruction
		data_ready = i_op_rdy && (!need_rd0 || i_sramrd0_rdy) && (!need_rd1 || i_sramrd1_rdy);
		to_dram = i_to_dram != alu_pkg::DRAM_NONE;
	end

	assign o_dramwd_rdy = data_ready && to_dram;
	// A DRAM instruction waits for the write to be taken
	assign op_ack = data_ready && (to_dram ? i_dramwd_ack : 1'b1);

	assign o_op_ack      = op_ack;
	assign o_inst_commit = op_ack;
	assign o_sramrd0_ack = op_ack && need_rd0;
	assign o_sramrd1_ack = op_ack && need_rd1;

	// Write-back to register file and temporary buffer
	assign wb.reg_we    = op_ack && i_to_reg;
	assign wb.reg_waddr = i_reg_waddr;
	assign wb.tbuf_we   = op_ack && i_to_temp;
	assign wb.wdata     = result;

endmodule

// File: rtl/vreg_file.sv
`timescale 1ns/1ns

module vreg_file (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  alu_pkg::reg_addr_t i_raddr,
	output alu_pkg::tvec_t     o_rdata,
	alu_wb_if.reg_sink         wb
);

	// REG_NWORD vectors of VSIZE lanes
	alu_pkg::tdata_t mem [alu_pkg::REG_NWORD][alu_pkg::VSIZE];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int w = 0; w < alu_pkg::REG_NWORD; w++) begin
				for (int i = 0; i < alu_pkg::VSIZE; i++) begin
					mem[w][i] <= '0;
				end
			end
		end else if (wb.reg_we) begin
			for (int i = 0; i < alu_pkg::VSIZE; i++) begin
				mem[wb.reg_waddr][i] <= wb.wdata[i];
			end
		end
	end

	// Combinational read, a same-cycle write shows up next cycle
	always_comb begin
		for (int i = 0; i < alu_pkg::VSIZE; i++) begin
			o_rdata[i] = mem[i_raddr][i];
		end
	end

endmodule

// File: rtl/tmp_buf.sv
`timescale 1ns/1ns

module tmp_buf (
	input  logic           i_clk,
	input  logic           i_rst_n,
	output alu_pkg::tvec_t o_tbuf0,
	output alu_pkg::tvec_t o_tbuf1,
	alu_wb_if.tbuf_sink    wb
);

	// Entry 0 is the newest result
	alu_pkg::tdata_t entry [alu_pkg::TBUF_SIZE][alu_pkg::VSIZE];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int e = 0; e < alu_pkg::TBUF_SIZE; e++) begin
				for (int i = 0; i < alu_pkg::VSIZE; i++) begin
					entry[e][i] <= '0;
				end
			end
		end else if (wb.tbuf_we) begin
			// Shift older results down one slot
			for (int e = alu_pkg::TBUF_SIZE - 1; e > 0; e--) begin
				entry[e] <= entry[e-1];
			end
			entry[0] <= wb.wdata;
		end
	end

	assign o_tbuf0 = entry[0];
	assign o_tbuf1 = entry[1];

endmodule

// File: rtl/alu_subsys.sv
`timescale 1ns/1ns

module alu_subsys (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	// Instruction
	input  logic                 i_op_rdy,
	output logic                 o_op_ack,
	input  alu_pkg::opcode_t     i_opcode,
	input  alu_pkg::shamt_t      i_shamt,
	input  alu_pkg::src_t        i_a,
	input  alu_pkg::src_t        i_b,
	input  alu_pkg::src_t        i_c,
	input  alu_pkg::tdata_t      i_const_a,
	input  alu_pkg::tdata_t      i_const_b,
	input  alu_pkg::tdata_t      i_const_c,
	input  alu_pkg::reg_addr_t   i_reg_raddr,
	input  logic                 i_to_reg,
	input  alu_pkg::reg_addr_t   i_reg_waddr,
	input  logic                 i_to_temp,
	input  alu_pkg::dram_mode_t  i_to_dram,
	// SRAM read streams
	input  logic                 i_sramrd0_rdy,
	output logic                 o_sramrd0_ack,
	input  alu_pkg::dvec_t       i_sramrd0,
	input  logic                 i_sramrd1_rdy,
	output logic                 o_sramrd1_ack,
	input  alu_pkg::dvec_t       i_sramrd1,
	// DRAM write stream
	output logic                 o_dramwd_rdy,
	input  logic                 i_dramwd_ack,
	output alu_pkg::dvec_t       o_dramwd,
	output logic                 o_inst_commit
);

	alu_pkg::reg_addr_t rf_raddr;
	alu_pkg::tvec_t     rf_rdata;
	alu_pkg::tvec_t     tbuf0;
	alu_pkg::tvec_t     tbuf1;

	// Write-back from the ALU to both storage blocks
	alu_wb_if wb_if ();

	vec_alu u_alu (
		.i_op_rdy      (i_op_rdy),
		.o_op_ack      (o_op_ack),
		.i_opcode      (i_opcode),
		.i_shamt       (i_shamt),
		.i_a           (i_a),
		.i_b           (i_b),
		.i_c           (i_c),
		.i_const_a     (i_const_a),
		.i_const_b     (i_const_b),
		.i_const_c     (i_const_c),
		.i_reg_raddr   (i_reg_raddr),
		.i_to_reg      (i_to_reg),
		.i_reg_waddr   (i_reg_waddr),
		.i_to_temp     (i_to_temp),
		.i_to_dram     (i_to_dram),
		.o_rf_raddr    (rf_raddr),
		.i_rf_rdata    (rf_rdata),
		.i_tbuf0       (tbuf0),
		.i_tbuf1       (tbuf1),
		.i_sramrd0_rdy (i_sramrd0_rdy),
		.o_sramrd0_ack (o_sramrd0_ack),
		.i_sramrd0     (i_sramrd0),
		.i_sramrd1_rdy (i_sramrd1_rdy),
		.o_sramrd1_ack (o_sramrd1_ack),
		.i_sramrd1     (i_sramrd1),
		.o_dramwd_rdy  (o_dramwd_rdy),
		.i_dramwd_ack  (i_dramwd_ack),
		.o_dramwd      (o_dramwd),
		.o_inst_commit (o_inst_commit),
		.wb            (wb_if.src)
	);

	vreg_file u_rf (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_raddr (rf_raddr),
		.o_rdata (rf_rdata),
		.wb      (wb_if.reg_sink)
	);

	tmp_buf u_tbuf (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.o_tbuf0 (tbuf0),
		.o_tbuf1 (tbuf1),
		.wb      (wb_if.tbuf_sink)
	);

endmodule

// File: tests/alu_subsys_chk.sv
`timescale 1ns/1ns

module alu_subsys_chk (
	input logic           i_clk,
	input logic           i_rst_n,
	input logic           i_op_rdy,
	input logic           i_op_ack,
	input logic           i_sramrd0_rdy,
	input logic           i_sramrd0_ack,
	input logic           i_sramrd1_rdy,
	input logic           i_sramrd1_ack,
	input logic           i_dramwd_rdy,
	input logic           i_dramwd_ack,
	input alu_pkg::dvec_t i_dramwd,
	input logic           i_inst_commit
);

	// Flattened DRAM lanes for the stability check
	logic [alu_pkg::VSIZE*alu_pkg::DATA_BW-1:0] dram_flat;

	always_comb begin
		for (int i = 0; i < alu_pkg::VSIZE; i++) begin
			dram_flat[i*alu_pkg::DATA_BW +: alu_pkg::DATA_BW] = i_dramwd[i];
		end
	end

	// ============================================================
	// Handshake rules
	// ============================================================
	a_op_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_op_ack |-> i_op_rdy) else $error("op ack seen without op rdy");
	a_rd0_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_sramrd0_ack |-> i_sramrd0_rdy) else $error("sramrd0 ack seen without rdy");
	a_rd1_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_sramrd1_ack |-> i_sramrd1_rdy) else $error("sramrd1 ack seen without rdy");
	a_dram_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dramwd_ack |-> i_dramwd_rdy) else $error("dramwd ack seen without rdy");
	a_commit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_inst_commit |-> i_op_rdy) else $error("commit seen without op rdy");

	// DRAM write request holds its data until taken
	a_dram_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dramwd_rdy && !i_dramwd_ack |=> i_dramwd_rdy && $stable(dram_flat))
		else $error("dramwd rdy or data changed before ack");

endmodule

bind alu_subsys alu_subsys_chk chk_i (
	.i_clk         (i_clk),
	.i_rst_n       (i_rst_n),
	.i_op_rdy      (i_op_rdy),
	.i_op_ack      (o_op_ack),
	.i_sramrd0_rdy (i_sramrd0_rdy),
	.i_sramrd0_ack (o_sramrd0_ack),
	.i_sramrd1_rdy (i_sramrd1_rdy),
	.i_sramrd1_ack (o_sramrd1_ack),
	.i_dramwd_rdy  (o_dramwd_rdy),
	.i_dramwd_ack  (i_dramwd_ack),
	.i_dramwd      (o_dramwd),
	.i_inst_commit (o_inst_commit)
);

// File: tests/tb_alu_subsys.sv
`timescale 1ns/1ns

module tb_alu_subsys;

	localparam int NTEST   = 23;
	localparam int MAX_DLY = 6;

	// One instruction with its DRAM ack delay
	typedef struct packed {
		alu_pkg::opcode_t    op;
		alu_pkg::shamt_t     sh;
		alu_pkg::src_t       a;
		alu_pkg::src_t       b;
		alu_pkg::src_t       c;
		alu_pkg::tdata_t     ca;
		alu_pkg::tdata_t     cb;
		alu_pkg::tdata_t     cc;
		alu_pkg::reg_addr_t  raddr;
		logic                to_reg;
		alu_pkg::reg_addr_t  waddr;
		logic                to_temp;
		alu_pkg::dram_mode_t mode;
		logic [3:0]          dly;
	} inst_t;

	logic           clk;
	logic           rst_n;
	logic           op_rdy;
	logic           op_ack;
	inst_t          cur;
	logic           rd0_rdy;
	logic           rd0_ack;
	alu_pkg::dvec_t rd0_data;
	logic           rd1_rdy;
	logic           rd1_ack;
	alu_pkg::dvec_t rd1_data;
	logic           dram_rdy;
	logic           dram_ack;
	alu_pkg::dvec_t dram_data;
	logic           commit;

	// Stimulus table and expected DRAM lanes
	inst_t          tab [NTEST];
	alu_pkg::dvec_t s0_tab [NTEST];
	alu_pkg::dvec_t s1_tab [NTEST];
	alu_pkg::dvec_t exp_tab [NTEST];
	string          names [NTEST];
	// Reference copies of the register file and temporary buffer
	int             shadow_rf [alu_pkg::REG_NWORD][alu_pkg::VSIZE];
	int             shadow_tb [2][alu_pkg::VSIZE];
	int             seed = 38693;
	int             test_errs;
	int             pass_count;
	int             fail_count;
	int             commit_count;

	alu_subsys dut_i (
		.i_clk (clk), .i_rst_n (rst_n),
		.i_op_rdy (op_rdy), .o_op_ack (op_ack),
		.i_opcode (cur.op), .i_shamt (cur.sh),
		.i_a (cur.a), .i_b (cur.b), .i_c (cur.c),
		.i_const_a (cur.ca), .i_const_b (cur.cb), .i_const_c (cur.cc),
		.i_reg_raddr (cur.raddr), .i_to_reg (cur.to_reg), .i_reg_waddr (cur.waddr),
		.i_to_temp (cur.to_temp), .i_to_dram (cur.mode),
		.i_sramrd0_rdy (rd0_rdy), .o_sramrd0_ack (rd0_ack), .i_sramrd0 (rd0_data),
		.i_sramrd1_rdy (rd1_rdy), .o_sramrd1_ack (rd1_ack), .i_sramrd1 (rd1_data),
		.o_dramwd_rdy (dram_rdy), .i_dramwd_ack (dram_ack), .o_dramwd (dram_data),
		.o_inst_commit (commit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(NTEST * (MAX_DLY + 10) * 8);
		$display("Watchdog expired, a test did not reach its commit in time");
		$display("Result: FAILED");
		$finish;
	end

	// ============================================================
	// Reference model of the lane rules
	// ============================================================
	function automatic int wrap16(input int v);
		logic signed [15:0] t;
		t = v[15:0];
		return int'(t);
	endfunction

	function automatic int wrap8(input int v);
		logic signed [7:0] t;
		t = v[7:0];
		return int'(t);
	endfunction

	function automatic int lane_model(input int op, input int sh, input int a, input int b,
		input int c);
		int r;
		case (op)
			0:       r = (a + b + c) >>> sh;
			1:       r = (a + b - c) >>> sh;
			2:       r = a + wrap16(((wrap8(b) - wrap8(c)) ** 2) >>> sh);
			3:       r = a + (((b > c) ? b - c : c - b) >>> sh);
			4:       r = a + ((wrap8(b) * wrap8(c)) >>> sh);
			default: r = 0;
		endcase
		return wrap16(r);
	endfunction

	function automatic int operand(input alu_pkg::src_t src, input alu_pkg::tdata_t cval,
		input int k, input int lane);
		case (src)
			alu_pkg::SRC_CONST: return int'(cval);
			alu_pkg::SRC_REG:   return shadow_rf[tab[k].raddr][lane];
			alu_pkg::SRC_SRAM0: return wrap8(int'(s0_tab[k][lane]));
			alu_pkg::SRC_SRAM1: return wrap8(int'(s1_tab[k][lane]));
			alu_pkg::SRC_TBUF0: return shadow_tb[0][lane];
			alu_pkg::SRC_TBUF1: return shadow_tb[1][lane];
			default:            return 0;
		endcase
	endfunction

	task automatic compute_expected();
		int res [alu_pkg::VSIZE];
		int t;
		for (int k = 0; k < NTEST; k++) begin
			for (int i = 0; i < alu_pkg::VSIZE; i++) begin
				res[i] = lane_model(int'(tab[k].op), int'(tab[k].sh),
					operand(tab[k].a, tab[k].ca, k, i), operand(tab[k].b, tab[k].cb, k, i),
					operand(tab[k].c, tab[k].cc, k, i));
				t = res[i] >>> (2 * int'(tab[k].mode));
				exp_tab[k][i] = alu_pkg::data_t'(t);
			end
			for (int i = 0; i < alu_pkg::VSIZE; i++) begin
				if (tab[k].to_reg) shadow_rf[tab[k].waddr][i] = res[i];
				if (tab[k].to_temp) begin
					shadow_tb[1][i] = shadow_tb[0][i];
					shadow_tb[0][i] = res[i];
				end
			end
		end
	endtask

	// ============================================================
	// Table construction
	// ============================================================
	task automatic set_entry(input int k, input string nm, input alu_pkg::opcode_t op,
		input int sh, input alu_pkg::src_t a, input alu_pkg::src_t b, input alu_pkg::src_t c,
		input int mode, input int dly);
		tab[k] = '0;
		names[k] = nm;
		tab[k].op = op;
		tab[k].sh = alu_pkg::shamt_t'(sh);
		tab[k].a = a;
		tab[k].b = b;
		tab[k].c = c;
		// Small constants keep the low byte equal to the full value
		tab[k].ca = alu_pkg::tdata_t'($random(seed) % 100);
		tab[k].cb = alu_pkg::tdata_t'($random(seed) % 100);
		tab[k].cc = alu_pkg::tdata_t'($random(seed) % 100);
		tab[k].mode = alu_pkg::dram_mode_t'(mode);
		tab[k].dly = 4'(dly);
		for (int i = 0; i < alu_pkg::VSIZE; i++) begin
			s0_tab[k][i] = alu_pkg::data_t'($random(seed));
			s1_tab[k][i] = alu_pkg::data_t'($random(seed));
		end
	endtask

	task automatic build_table();
		for (int k = 0; k < 15; k++) begin
			set_entry(k, $sformatf("op%0d_mode%0d", k / 3, k % 3), alu_pkg::opcode_t'(k / 3),
				k % 4, alu_pkg::SRC_CONST, alu_pkg::SRC_CONST, alu_pkg::SRC_CONST, k % 3, k % 3);
		end
		set_entry(15, "sram_a_c", alu_pkg::OP_SUB, 1, alu_pkg::SRC_SRAM0, alu_pkg::SRC_CONST,
			alu_pkg::SRC_SRAM1, 0, 1);
		set_entry(16, "reg_write", alu_pkg::OP_ADD, 0, alu_pkg::SRC_SRAM0, alu_pkg::SRC_CONST,
			alu_pkg::SRC_CONST, 0, 0);
		tab[16].to_reg = 1'b1;
		tab[16].waddr = 4'd9;
		set_entry(17, "reg_read", alu_pkg::OP_ADD, 0, alu_pkg::SRC_REG, alu_pkg::SRC_CONST,
			alu_pkg::SRC_CONST, 0, 2);
		tab[17].raddr = 4'd9;
		tab[17].cb = '0;
		tab[17].cc = '0;
		set_entry(18, "push_old", alu_pkg::OP_ADD, 0, alu_pkg::SRC_SRAM0, alu_pkg::SRC_CONST,
			alu_pkg::SRC_CONST, 0, 0);
		tab[18].to_temp = 1'b1;
		set_entry(19, "push_new", alu_pkg::OP_MAC, 1, alu_pkg::SRC_SRAM1, alu_pkg::SRC_SRAM0,
			alu_pkg::SRC_CONST, 0, 0);
		tab[19].to_temp = 1'b1;
		set_entry(20, "tbuf_new", alu_pkg::OP_ADD, 0, alu_pkg::SRC_TBUF0, alu_pkg::SRC_CONST,
			alu_pkg::SRC_CONST, 0, 1);
		tab[20].cb = '0;
		tab[20].cc = '0;
		set_entry(21, "tbuf_old", alu_pkg::OP_ADD, 0, alu_pkg::SRC_TBUF1, alu_pkg::SRC_CONST,
			alu_pkg::SRC_CONST, 0, 0);
		tab[21].cb = '0;
		tab[21].cc = '0;
		set_entry(22, "backpress", alu_pkg::OP_ABSDIST, 2, alu_pkg::SRC_SRAM1,
			alu_pkg::SRC_SRAM0, alu_pkg::SRC_SRAM1, 1, MAX_DLY);
	endtask

	// ============================================================
	// Driver and checks
	// ============================================================
	task automatic report_error(input string msg);
		$display("%s", msg);
		test_errs++;
	endtask

	task automatic run_entry(input int k);
		int             waited;
		logic           done;
		logic           seen;
		logic           need0;
		logic           need1;
		alu_pkg::dvec_t held;
		waited = 0;
		done = 1'b0;
		seen = 1'b0;
		@(posedge clk);
		#1;
		cur = tab[k];
		rd0_data = s0_tab[k];
		rd1_data = s1_tab[k];
		// SRAM streams hold off for the first cycle of each instruction
		rd0_rdy = 1'b0;
		rd1_rdy = 1'b0;
		op_rdy = 1'b1;
		need0 = (cur.a == alu_pkg::SRC_SRAM0) || (cur.b == alu_pkg::SRC_SRAM0)
			|| (cur.c == alu_pkg::SRC_SRAM0);
		need1 = (cur.a == alu_pkg::SRC_SRAM1) || (cur.b == alu_pkg::SRC_SRAM1)
			|| (cur.c == alu_pkg::SRC_SRAM1);
		while (!done) begin
			@(negedge clk);
			for (int i = 0; i < alu_pkg::VSIZE; i++) begin
				if (seen && dram_rdy && dram_data[i] !== held[i])
					report_error($sformatf("FAIL %s: DRAM lane %0d changed before ack", names[k], i));
			end
			held = dram_data;
			seen = dram_rdy;
			if (((need0 && !rd0_rdy) || (need1 && !rd1_rdy)) && (dram_rdy || commit))
				report_error($sformatf("FAIL %s: DRAM rdy or commit before SRAM data is ready",
					names[k]));
			if (commit !== op_ack) report_error($sformatf("FAIL %s: commit differs from op ack",
				names[k]));
			if (commit) begin
				done = 1'b1;
				commit_count++;
				if (!dram_ack) report_error($sformatf("FAIL %s: commit before the DRAM ack",
					names[k]));
				if (rd0_ack !== need0 || rd1_ack !== need1)
					report_error($sformatf("FAIL %s: SRAM acks expected %b%b, actual %b%b",
						names[k], need1, need0, rd1_ack, rd0_ack));
				for (int i = 0; i < alu_pkg::VSIZE; i++) begin
					if (dram_data[i] !== exp_tab[k][i])
						report_error($sformatf("FAIL %s lane %0d: expected %h, actual %h",
							names[k], i, exp_tab[k][i], dram_data[i]));
				end
			end else if (rd0_ack || rd1_ack) begin
				report_error($sformatf("FAIL %s: SRAM ack without a commit", names[k]));
			end
			@(posedge clk);
			#1;
			if (done) begin
				op_rdy = 1'b0;
				dram_ack = 1'b0;
			end else if (dram_rdy) begin
				dram_ack = (waited >= int'(tab[k].dly));
				waited++;
			end
			// Both SRAM streams offer their data from the second cycle on
			rd0_rdy = 1'b1;
			rd1_rdy = 1'b1;
		end
		// One idle cycle, no second commit may follow
		@(negedge clk);
		if (commit || rd0_ack || rd1_ack || dram_rdy)
			report_error($sformatf("FAIL %s: activity after the commit", names[k]));
	endtask

	task automatic finish_test(input string nm);
		if (test_errs == 0) begin
			pass_count++;
			$display("test %s ok", nm);
		end else begin
			fail_count++;
			$display("test %s failed with %0d errors", nm, test_errs);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		op_rdy = 1'b0;
		cur = '0;
		rd0_rdy = 1'b1;
		rd1_rdy = 1'b1;
		rd0_data = '{default: '0};
		rd1_data = '{default: '0};
		dram_ack = 1'b0;
		pass_count = 0;
		fail_count = 0;
		commit_count = 0;
		build_table();
		compute_expected();
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// Idle with op_rdy low while both SRAM streams offer data
		test_errs = 0;
		repeat (3) begin
			@(negedge clk);
			if (commit || op_ack || rd0_ack || rd1_ack || dram_rdy)
				report_error("FAIL reset_idle: handshake or commit active with op_rdy low");
		end
		finish_test("reset_idle");
		for (int k = 0; k < NTEST; k++) begin
			test_errs = 0;
			run_entry(k);
			finish_test(names[k]);
		end
		$display("tests %0d, passed %0d, failed %0d, commits %0d", NTEST + 1, pass_count,
			fail_count, commit_count);
		if (fail_count == 0 && commit_count == NTEST) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
rtl/alu_pkg.sv
rtl/alu_wb_if.sv
rtl/vec_alu.sv
rtl/vreg_file.sv
rtl/tmp_buf.sv
rtl/alu_subsys.sv
tests/alu_subsys_chk.sv
tests/tb_alu_subsys.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_alu_subsys
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = run.log

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Run the simulation, keep a log, and pass only if the pass line is present
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
